/* src/lcd_pkg.sv */
// shared addresses, constant words, buffer sizes, id width and state enums
package lcd_pkg;

  // read address map
  localparam logic [31:0] LCD_INPUT_ADDR   = 32'h1fd0_c000;
  localparam logic [31:0] TOUCH_INPUT_ADDR = 32'h1fd0_c004;

  // fixed read words
  localparam logic [31:0] TOUCH_IDLE_WORD = 32'hffff_ffff; // no touch pending
  localparam logic [31:0] UNMAPPED_WORD   = 32'heeee_eeee;

  localparam int ID_W = 4; // transaction id width

  // graph buffer geometry
  localparam int GRAPH_WORDS    = 7;
  localparam int DISPATCH_WORDS = 6; // last slot carries the graph size
  localparam int DISPATCH_GAP   = 2; // idle cycles between dispatches

  // counter widths derived from the sizes above
  localparam int BUF_IDX_W = $clog2(GRAPH_WORDS);
  localparam int GAP_W     = $clog2(DISPATCH_GAP + 1);

  typedef enum logic {
    r_addr,
    r_data
  } r_state_e;

  typedef enum logic [1:0] {
    w_idle,
    w_addr,
    w_data,
    w_resp
  } w_state_e;

  typedef enum logic {
    buf_fill,
    buf_dispatch
  } buf_state_e;

endpackage

/* src/lcd_axi_read.sv */
// read channel responder, one beat per address with address decode
`timescale 1ns/1ps
module lcd_axi_read
  import lcd_pkg::*;
(
  input  logic            pclk,
  input  logic            rst_n,
  input  logic [ID_W-1:0] arid,
  input  logic [31:0]     araddr,
  input  logic            arvalid,
  output logic            arready,
  output logic [ID_W-1:0] rid,
  output logic [31:0]     rdata,
  output logic [1:0]      rresp,
  output logic            rlast,
  output logic            rvalid,
  input  logic            rready,
  input  logic [31:0]     lcd_input_data
);

  r_state_e    state;
  logic [31:0] addr_q; // captured read address
  logic        ar_hs;
  logic        r_hs;

  // pick the read word for an address
  function automatic logic [31:0] decode_word(input logic [31:0] addr,
                                              input logic [31:0] lcd_word);
    case (addr)
      LCD_INPUT_ADDR:   return lcd_word;
      TOUCH_INPUT_ADDR: return TOUCH_IDLE_WORD;
      default:          return UNMAPPED_WORD;
    endcase
  endfunction

  assign ar_hs = arvalid && arready;
  assign r_hs  = rvalid && rready;
  assign rresp = 2'b00; // always okay

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      state   <= r_addr;
      arready <= 1'b1;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
    end else begin
      case (state)
        r_addr: if (ar_hs) begin
          state   <= r_data;
          arready <= 1'b0;
          rvalid  <= 1'b1;
          rlast   <= 1'b1; // single beat
        end
        r_data: if (r_hs) begin
          state   <= r_addr;
          arready <= 1'b1;
          rvalid  <= 1'b0;
          rlast   <= 1'b0;
        end
        default: state <= r_addr;
      endcase
    end
  end

  // id, address and read word
  always_ff @(posedge pclk) begin
    if (ar_hs) begin
      rid    <= arid;
      addr_q <= araddr;
      rdata  <= decode_word(araddr, lcd_input_data);
    end else if (rvalid && !rready) begin
      rdata <= decode_word(addr_q, lcd_input_data); // follow the lcd input
    end
  end

endmodule

/* src/lcd_axi_write.sv */
// write address, data and response responder with direct lcd write pulse
`timescale 1ns/1ps
module lcd_axi_write
  import lcd_pkg::*;
(
  input  logic            pclk,
  input  logic            rst_n,
  input  logic [ID_W-1:0] awid,
  input  logic [31:0]     awaddr,
  input  logic            awvalid,
  output logic            awready,
  input  logic [31:0]     wdata,
  input  logic [3:0]      wstrb,
  input  logic            wvalid,
  output logic            wready,
  output logic [ID_W-1:0] bid,
  output logic [1:0]      bresp,
  output logic            bvalid,
  input  logic            bready,
  input  logic            buffer_full,
  output logic [31:0]     lcd_addr,
  output logic [31:0]     lcd_data,
  output logic            write_lcd,
  output logic            word_accept,
  output logic [31:0]     word_addr,
  output logic [31:0]     word_data
);

  w_state_e    state;
  logic [31:0] addr_q;
  logic [31:0] data_q;
  logic        strobe_q; // one cycle after a full strobe data beat
  logic        aw_hs;
  logic        w_hs;
  logic        b_hs;
  logic        full_strb;

  assign aw_hs     = awvalid && awready;
  assign w_hs      = wvalid && wready;
  assign b_hs      = bvalid && bready;
  assign full_strb = (wstrb == 4'hf);
  assign bresp     = 2'b00;

  // same beat goes to the lcd and to the graph buffer
  assign lcd_addr    = addr_q;
  assign lcd_data    = data_q;
  assign write_lcd   = strobe_q;
  assign word_addr   = addr_q;
  assign word_data   = data_q;
  assign word_accept = strobe_q;

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      state    <= w_idle;
      awready  <= 1'b0;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= 1'b0;
      case (state)
        w_idle: if (!buffer_full) begin // hold off while a graph drains
          state   <= w_addr;
          awready <= 1'b1;
        end
        w_addr: if (aw_hs) begin
          state   <= w_data;
          awready <= 1'b0;
          wready  <= 1'b1;
        end
        w_data: if (w_hs) begin
          state    <= w_resp;
          wready   <= 1'b0;
          bvalid   <= 1'b1;
          strobe_q <= full_strb; // partial strobes only get a response
        end
        w_resp: if (b_hs) begin
          state  <= w_idle;
          bvalid <= 1'b0;
        end
        default: state <= w_idle;
      endcase
    end
  end

  // payload capture
  always_ff @(posedge pclk) begin
    if (aw_hs) begin
      bid    <= awid;
      addr_q <= awaddr;
    end
    if (w_hs) begin
      data_q <= wdata;
    end
  end

endmodule

/* src/lcd_graph_buffer.sv */
// seven slot graph capture buffer and paced dispatcher to the lcd decoder
`timescale 1ns/1ps
module lcd_graph_buffer
  import lcd_pkg::*;
(
  input  logic        pclk,
  input  logic        rst_n,
  input  logic        word_accept,
  input  logic [31:0] word_addr,
  input  logic [31:0] word_data,
  input  logic        write_ok,
  output logic        buffer_full,
  output logic [31:0] buffer_addr,
  output logic [31:0] buffer_data,
  output logic        data_valid,
  output logic [31:0] graph_size
);

  buf_state_e           state;
  logic [31:0]          slot_addr [GRAPH_WORDS];
  logic [31:0]          slot_data [GRAPH_WORDS];
  logic [BUF_IDX_W-1:0] fill_cnt; // next free slot
  logic [BUF_IDX_W-1:0] send_idx; // next slot to dispatch
  logic [GAP_W-1:0]     gap_cnt;
  logic                 gap_done;
  logic                 sent_all;
  logic                 send_now;
  logic                 graph_done;

  assign gap_done   = (gap_cnt == GAP_W'(DISPATCH_GAP));
  assign sent_all   = (send_idx == BUF_IDX_W'(DISPATCH_WORDS));
  assign send_now   = (state == buf_dispatch) && write_ok && gap_done && !sent_all;
  assign graph_done = (state == buf_dispatch) && write_ok && sent_all;

  // slot storage
  always_ff @(posedge pclk) begin
    if (graph_done) begin
      for (int i = 0; i < GRAPH_WORDS; i++) begin
        slot_addr[i] <= '0;
        slot_data[i] <= '0;
      end
    end else if (state == buf_fill && word_accept) begin
      slot_addr[fill_cnt] <= word_addr;
      slot_data[fill_cnt] <= word_data;
    end
  end

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      state       <= buf_fill;
      fill_cnt    <= '0;
      send_idx    <= '0;
      gap_cnt     <= GAP_W'(DISPATCH_GAP); // first word may go at once
      buffer_full <= 1'b0;
      data_valid  <= 1'b0;
      graph_size  <= '0;
    end else begin
      data_valid <= 1'b0;
      case (state)
        buf_fill: begin
          if (word_accept) begin
            if (fill_cnt == BUF_IDX_W'(GRAPH_WORDS - 1)) begin
              fill_cnt    <= '0;
              buffer_full <= 1'b1; // stall the write side
              state       <= buf_dispatch;
            end else begin
              fill_cnt <= fill_cnt + 1'b1;
            end
          end
        end
        buf_dispatch: begin
          if (send_now) begin
            send_idx   <= send_idx + 1'b1;
            gap_cnt    <= '0;
            data_valid <= 1'b1;
            graph_size <= slot_data[GRAPH_WORDS-1];
          end else if (graph_done) begin
            // decoder took the last word, reopen for the next graph
            send_idx    <= '0;
            gap_cnt     <= GAP_W'(DISPATCH_GAP);
            buffer_full <= 1'b0;
            graph_size  <= '0;
            state       <= buf_fill;
          end else if (!gap_done) begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        default: state <= buf_fill;
      endcase
    end
  end

  // word handed to the decoder
  always_ff @(posedge pclk) begin
    if (send_now) begin
      buffer_addr <= slot_addr[send_idx];
      buffer_data <= slot_data[send_idx];
    end
  end

endmodule

/* src/lcd_ctrl.sv */
// lcd controller top with read, write and graph buffer blocks
`timescale 1ns/1ps
module lcd_ctrl
  import lcd_pkg::*;
(
  input  logic            pclk,
  input  logic            rst_n,
  // read address and data
  input  logic [ID_W-1:0] arid,
  input  logic [31:0]     araddr,
  input  logic            arvalid,
  output logic            arready,
  output logic [ID_W-1:0] rid,
  output logic [31:0]     rdata,
  output logic [1:0]      rresp,
  output logic            rlast,
  output logic            rvalid,
  input  logic            rready,
  // write address, data and response
  input  logic [ID_W-1:0] awid,
  input  logic [31:0]     awaddr,
  input  logic            awvalid,
  output logic            awready,
  input  logic [31:0]     wdata,
  input  logic [3:0]      wstrb,
  input  logic            wvalid,
  output logic            wready,
  output logic [ID_W-1:0] bid,
  output logic [1:0]      bresp,
  output logic            bvalid,
  input  logic            bready,
  // lcd side
  output logic [31:0]     lcd_addr,
  output logic [31:0]     lcd_data,
  output logic            write_lcd,
  output logic [31:0]     buffer_addr,
  output logic [31:0]     buffer_data,
  output logic            data_valid,
  output logic [31:0]     graph_size,
  input  logic [31:0]     lcd_input_data,
  input  logic            write_ok
);

  logic        word_accept;
  logic [31:0] word_addr;
  logic [31:0] word_data;
  logic        buffer_full;

  lcd_axi_read i_axi_read (
    .pclk, .rst_n,
    .arid, .araddr, .arvalid, .arready,
    .rid, .rdata, .rresp, .rlast, .rvalid, .rready,
    .lcd_input_data
  );

  lcd_axi_write i_axi_write (
    .pclk, .rst_n,
    .awid, .awaddr, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .bid, .bresp, .bvalid, .bready,
    .buffer_full,
    .lcd_addr, .lcd_data, .write_lcd,
    .word_accept, .word_addr, .word_data
  );

  lcd_graph_buffer i_graph_buffer (
    .pclk, .rst_n,
    .word_accept, .word_addr, .word_data,
    .write_ok, .buffer_full,
    .buffer_addr, .buffer_data, .data_valid, .graph_size
  );

endmodule

/* test/lcd_ctrl_assert.sv */
// bus handshake and strobe assertions bound into the lcd controller top
`timescale 1ns/1ps
module lcd_ctrl_assert (
  input logic pclk,
  input logic rst_n,
  input logic arvalid,
  input logic arready,
  input logic rvalid,
  input logic rready,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input logic bvalid,
  input logic bready,
  input logic write_lcd,
  input logic data_valid,
  input logic buffer_full
);

  int fail_count = 0;

  // a raised valid waits for its ready
  ar_hold: assert property (@(posedge pclk) disable iff (!rst_n) arvalid && !arready |=> arvalid)
    else begin fail_count++; $error("arvalid dropped before handshake"); end
  r_hold: assert property (@(posedge pclk) disable iff (!rst_n) rvalid && !rready |=> rvalid)
    else begin fail_count++; $error("rvalid dropped before handshake"); end
  aw_hold: assert property (@(posedge pclk) disable iff (!rst_n) awvalid && !awready |=> awvalid)
    else begin fail_count++; $error("awvalid dropped before handshake"); end
  w_hold: assert property (@(posedge pclk) disable iff (!rst_n) wvalid && !wready |=> wvalid)
    else begin fail_count++; $error("wvalid dropped before handshake"); end
  b_hold: assert property (@(posedge pclk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
    else begin fail_count++; $error("bvalid dropped before handshake"); end

  // single cycle strobes
  lcd_pulse: assert property (@(posedge pclk) disable iff (!rst_n) write_lcd |=> !write_lcd)
    else begin fail_count++; $error("write_lcd longer than one cycle"); end
  dv_pulse: assert property (@(posedge pclk) disable iff (!rst_n) data_valid |=> !data_valid)
    else begin fail_count++; $error("data_valid longer than one cycle"); end

  no_aw_full: assert property (@(posedge pclk) disable iff (!rst_n) !(awready && buffer_full))
    else begin fail_count++; $error("awready high while graph buffer full"); end

endmodule

bind lcd_ctrl lcd_ctrl_assert i_ctrl_assert (.*);

/* test/lcd_checker.sv */
// reference model that watches the controller ports and compares responses
`timescale 1ns/1ps
module lcd_checker
  import lcd_pkg::*;
(
  input  logic            pclk,
  input  logic            rst_n,
  input  logic [ID_W-1:0] arid,
  input  logic [31:0]     araddr,
  input  logic            arvalid,
  input  logic            arready,
  input  logic [ID_W-1:0] rid,
  input  logic [31:0]     rdata,
  input  logic [1:0]      rresp,
  input  logic            rlast,
  input  logic            rvalid,
  input  logic            rready,
  input  logic [ID_W-1:0] awid,
  input  logic [31:0]     awaddr,
  input  logic            awvalid,
  input  logic            awready,
  input  logic [31:0]     wdata,
  input  logic [3:0]      wstrb,
  input  logic            wvalid,
  input  logic            wready,
  input  logic [ID_W-1:0] bid,
  input  logic [1:0]      bresp,
  input  logic            bvalid,
  input  logic            bready,
  input  logic [31:0]     lcd_addr,
  input  logic [31:0]     lcd_data,
  input  logic            write_lcd,
  input  logic [31:0]     buffer_addr,
  input  logic [31:0]     buffer_data,
  input  logic            data_valid,
  input  logic [31:0]     graph_size,
  input  logic [31:0]     lcd_input_data,
  input  logic            write_ok,
  output int              errors,
  output int              checks,
  output logic            busy
);

  logic [31:0]     rd_addr;
  logic [ID_W-1:0] rd_id;
  logic [31:0]     wr_addr;
  logic [ID_W-1:0] wr_id;
  logic [31:0]     lcd_last; // lcd input seen one edge earlier
  logic            wok_last;
  logic            lcd_due;
  logic [63:0]     lcd_exp;
  logic [31:0]     size_exp;
  int              since_pulse;
  logic [63:0]     graph_q[$]; // full strobe words of the graph being filled
  logic [63:0]     disp_q[$];  // words still owed to the decoder

  initial begin
    errors      = 0;
    checks      = 0;
    busy        = 1'b0;
    since_pulse = 3;
  end

  task automatic report_failure(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic compare_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  always @(posedge pclk) begin
    logic [63:0] ent;
    if (rst_n) begin
      if (arvalid && arready) begin
        rd_addr <= araddr;
        rd_id   <= arid;
      end
      if (rvalid && rready) begin
        if (rd_addr == LCD_INPUT_ADDR)
          compare_word("rdata lcd input", rdata, lcd_last);
        else if (rd_addr == TOUCH_INPUT_ADDR)
          compare_word("rdata touch", rdata, TOUCH_IDLE_WORD);
        else
          compare_word("rdata unmapped", rdata, UNMAPPED_WORD);
        compare_word("rid", 32'(rid), 32'(rd_id));
        compare_word("rlast", 32'(rlast), 32'd1);
        compare_word("rresp", 32'(rresp), 32'd0); // always okay
      end
      if (awvalid && awready) begin
        wr_addr <= awaddr;
        wr_id   <= awid;
        if (disp_q.size() != 0) report_failure("write address accepted during graph dispatch");
        compare_word("graph_size while filling", graph_size, 32'd0);
      end
      if (write_lcd || lcd_due) begin
        compare_word("write_lcd", 32'(write_lcd), 32'(lcd_due));
        if (lcd_due) begin
          compare_word("lcd_addr", lcd_addr, lcd_exp[63:32]);
          compare_word("lcd_data", lcd_data, lcd_exp[31:0]);
        end
      end
      lcd_due <= wvalid && wready && (wstrb == 4'hf); // partial strobes never reach the lcd
      if (wvalid && wready && wstrb == 4'hf) begin
        lcd_exp <= {wr_addr, wdata};
        graph_q.push_back({wr_addr, wdata});
        if (graph_q.size() == GRAPH_WORDS) begin
          for (int i = 0; i < DISPATCH_WORDS; i++) disp_q.push_back(graph_q[i]);
          size_exp <= graph_q[GRAPH_WORDS-1][31:0];
          graph_q.delete();
        end
      end
      if (bvalid && bready) begin
        compare_word("bid", 32'(bid), 32'(wr_id));
        compare_word("bresp", 32'(bresp), 32'd0);
      end
      since_pulse <= data_valid ? 1 : since_pulse + 1;
      if (data_valid) begin
        if (!wok_last) report_failure("data_valid sent while write_ok was low");
        if (since_pulse < 3) report_failure("data_valid pulses closer than three cycles");
        if (disp_q.size() == 0) begin
          report_failure("data_valid with no graph word waiting");
        end else begin
          ent = disp_q.pop_front();
          compare_word("buffer_addr", buffer_addr, ent[63:32]);
          compare_word("buffer_data", buffer_data, ent[31:0]);
          compare_word("graph_size", graph_size, size_exp);
        end
      end
    end
    wok_last <= write_ok;
    lcd_last <= lcd_input_data;
    busy     <= (disp_q.size() != 0);
  end

endmodule

/* test/tb_lcd_ctrl.sv */
// testbench top with clock, reset, random bus stimulus, decoder model and summary
`timescale 1ns/1ps
module tb_lcd_ctrl
  import lcd_pkg::*;
();

  localparam int N_READS     = 40;
  localparam int N_PARTIAL   = 6;
  localparam int N_GRAPHS    = 3;
  localparam int N_TXN       = N_READS + N_PARTIAL + N_GRAPHS * (GRAPH_WORDS + 2);
  localparam int TIMEOUT_CYC = 40 * N_TXN;

  logic            pclk;
  logic            rst_n;
  logic [ID_W-1:0] arid, rid, awid, bid;
  logic [31:0]     araddr, rdata, awaddr, wdata;
  logic            arvalid, arready, rvalid, rready, rlast;
  logic            awvalid, awready, wvalid, wready, bvalid, bready;
  logic [1:0]      rresp, bresp;
  logic [3:0]      wstrb;
  logic [31:0]     lcd_addr, lcd_data, buffer_addr, buffer_data, graph_size;
  logic [31:0]     lcd_input_data;
  logic            write_lcd, data_valid, write_ok;
  int              errors, checks, assert_errors;
  logic            busy;
  int              seed;
  int              cycle_cnt;
  int              pulse_cnt;
  int              tests_run, tests_failed, err_mark;
  logic [1:0]      hold, stall_cnt;

  lcd_ctrl i_lcd_ctrl (.*);
  lcd_checker i_check (.*);

  assign assert_errors = i_lcd_ctrl.i_ctrl_assert.fail_count;

  initial pclk = 1'b0;
  always #10 pclk = ~pclk;

  // bus back-pressure, lcd input and the decoder's write_ok model
  always @(posedge pclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_n) begin
      rready         <= ($random(seed) & 3) != 0;
      bready         <= ($random(seed) & 3) != 0;
      lcd_input_data <= $random(seed);
      if (data_valid) begin
        pulse_cnt <= pulse_cnt + 1;
        hold = 2'($random(seed)); // decoder busy 0 to 3 cycles
        write_ok  <= (hold == 2'd0);
        stall_cnt <= hold;
      end else if (stall_cnt != 2'd0) begin
        stall_cnt <= stall_cnt - 1'b1;
        write_ok  <= (stall_cnt == 2'd1);
      end
    end
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout: the run hung after %0d cycles", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic read_word(input logic [31:0] addr);
    arid    <= ID_W'($random(seed));
    araddr  <= addr;
    arvalid <= 1'b1;
    @(posedge pclk);
    while (!arready) @(posedge pclk);
    arvalid <= 1'b0;
    @(posedge pclk);
    while (!(rvalid && rready)) @(posedge pclk);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    awid    <= ID_W'($random(seed));
    awaddr  <= addr;
    awvalid <= 1'b1;
    @(posedge pclk);
    while (!awready) @(posedge pclk);
    awvalid <= 1'b0;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    @(posedge pclk);
    while (!wready) @(posedge pclk);
    wvalid <= 1'b0;
    @(posedge pclk);
    while (!(bvalid && bready)) @(posedge pclk);
  endtask

  task automatic close_test(input string name);
    int now_errors;
    @(posedge pclk); // let the checker finish this edge
    now_errors = errors + assert_errors;
    tests_run++;
    if (now_errors != err_mark) begin
      tests_failed++;
      $display("test %0d %s: failed, %0d new errors", tests_run, name, now_errors - err_mark);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    err_mark = now_errors;
  endtask

  initial begin
    logic [31:0] addr;
    logic [3:0]  strb;
    int          kind;
    seed           = 32'h4407;
    rst_n          = 1'b0;
    arid           = '0;
    araddr         = '0;
    arvalid        = 1'b0;
    rready         = 1'b0;
    awid           = '0;
    awaddr         = '0;
    awvalid        = 1'b0;
    wdata          = '0;
    wstrb          = '0;
    wvalid         = 1'b0;
    bready         = 1'b0;
    lcd_input_data = '0;
    write_ok       = 1'b1;
    cycle_cnt      = 0;
    pulse_cnt      = 0;
    stall_cnt      = 2'd0;
    tests_run      = 0;
    tests_failed   = 0;
    err_mark       = 0;
    repeat (2) @(posedge pclk);
    rst_n <= 1'b1;
    @(posedge pclk);

    for (int i = 0; i < N_READS; i++) begin
      kind = $random(seed) & 3;
      addr = $random(seed);
      if (kind == 0) addr = LCD_INPUT_ADDR;
      else if (kind == 1) addr = TOUCH_INPUT_ADDR;
      read_word(addr);
    end
    close_test("random reads");

    for (int i = 0; i < N_PARTIAL; i++) begin
      strb = 4'($random(seed)) & 4'h7; // never all four lanes
      write_word($random(seed), $random(seed), strb);
    end
    close_test("partial strobe writes");

    // last partial write of each graph raises awvalid while the graph dispatches
    for (int g = 1; g <= N_GRAPHS; g++) begin
      for (int k = 0; k <= GRAPH_WORDS + 1; k++) begin
        strb = (k == 3 || k == GRAPH_WORDS + 1) ? (4'($random(seed)) & 4'h7) : 4'hf;
        write_word($random(seed), $random(seed), strb);
      end
      while (pulse_cnt < g * DISPATCH_WORDS) @(posedge pclk);
      close_test($sformatf("graph %0d dispatch", g));
    end

    repeat (4) @(posedge pclk);
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion errors",
             tests_run, tests_failed, checks, errors, assert_errors);
    if (tests_failed == 0 && errors == 0 && assert_errors == 0 && !busy) begin
      $display("*** PASSED ***");
    end else begin
      if (busy) $display("graph words were never sent to the decoder");
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
src/lcd_pkg.sv
src/lcd_axi_read.sv
src/lcd_axi_write.sv
src/lcd_graph_buffer.sv
src/lcd_ctrl.sv
test/lcd_ctrl_assert.sv
test/lcd_checker.sv
test/tb_lcd_ctrl.sv

/* Makefile */
# Verilator build and run of the lcd controller testbench
VERILATOR ?= verilator
TOP       ?= tb_lcd_ctrl
FLAGS     ?= --binary --timing --assert -Wno-fatal
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
